// File: design/l1_cache_defines.svh
`ifndef L1_CACHE_DEFINES_SVH
`define L1_CACHE_DEFINES_SVH

// Geometry of the two-way L1 data cache

// One cache line is also one Wishbone data word
`define L1_LINE_BITS 128

// One select bit per byte lane of a line
`define L1_SEL_BITS 16

// Sets per way
`define L1_SETS 8

// Set index taken from the low bits of the line address
`define L1_INDEX_BITS 3

// Tag is the rest of the line address
`define L1_TAG_BITS 9

// Line address carried on both Wishbone ports
`define L1_ADDR_BITS 12

`endif

// File: design/cache_types_pkg.sv
`include "l1_cache_defines.svh"

package cache_types_pkg;

    // Storage of one way entry
    typedef logic [`L1_LINE_BITS-1:0]  cache_line_t;   // Whole line, byte i in bits 8i+7..8i
    typedef logic [`L1_TAG_BITS-1:0]   cache_tag_t;    // Upper part of the line address
    typedef logic [`L1_INDEX_BITS-1:0] cache_index_t;  // Selects one of the sets

    // Controller sequencing
    // IDLE also performs the lookup, so a hit needs no extra state
    typedef enum logic [1:0] {
        IDLE      = 2'd0,  // Lookup and hit service
        WRITEBACK = 2'd1,  // Dirty victim goes out to memory
        FILL      = 2'd2   // Missing line comes in from memory
    } cache_state_t;

endpackage : cache_types_pkg

// File: design/bus_types_pkg.sv
`include "l1_cache_defines.svh"

package bus_types_pkg;

    // Wishbone signals shared by the CPU port and the memory port
    typedef logic [`L1_ADDR_BITS-1:0] wb_addr_t;  // Line address, no byte offset bits
    typedef logic [`L1_SEL_BITS-1:0]  wb_sel_t;   // Bit i enables byte i of the line
    typedef logic [`L1_LINE_BITS-1:0] wb_data_t;  // Same size as a cache line

    // Memory side always moves whole lines
    localparam wb_sel_t WB_SEL_ALL = '1;

endpackage : bus_types_pkg

// File: design/cache_way.sv
`timescale 1ns/10ps
`include "l1_cache_defines.svh"

module cache_way
    import cache_types_pkg::*;
    import bus_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  logic         load,
    input  logic         load_type,  // High for a fill from memory
    input  wb_sel_t      byte_sel,
    input  cache_tag_t   tag_in,
    input  cache_index_t index,
    input  cache_line_t  data_in,

    output cache_tag_t   tag_out,
    output cache_line_t  data_out,
    output logic         dirty,
    output logic         hit
);

    cache_tag_t             tag_arr   [`L1_SETS];
    cache_line_t            line_arr  [`L1_SETS];
    logic [`L1_SETS-1:0]    valid_arr;
    logic [`L1_SETS-1:0]    dirty_arr;

    // Status bits per set
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_arr <= '0;
            dirty_arr <= '0;
        end else if (load) begin
            valid_arr[index] <= 1'b1;
            dirty_arr[index] <= ~load_type;  // Fill is clean, CPU store makes it dirty
        end
    end

    // Tag and line storage
    always_ff @(posedge clk) begin
        if (load) begin
            tag_arr[index] <= tag_in;  // Unchanged on a store hit, new tag on a fill
            for (int i = 0; i < `L1_SEL_BITS; i++) begin
                if (byte_sel[i]) begin
                    line_arr[index][8*i +: 8] <= data_in[8*i +: 8];
                end
            end
        end
    end

    // Asynchronous read at the addressed set
    assign tag_out  = tag_arr[index];
    assign data_out = line_arr[index];
    assign dirty    = dirty_arr[index];
    assign hit      = valid_arr[index] && (tag_arr[index] == tag_in);

    // A fill must replace every byte, otherwise stale data would be marked clean
    a_fill_full_line : assert property (
        @(posedge clk) disable iff (!rst_n)
        (load && load_type) |-> (byte_sel == WB_SEL_ALL)
    );

endmodule : cache_way

// File: design/cache_l1_datapath.sv
`timescale 1ns/10ps
`include "l1_cache_defines.svh"

module cache_l1_datapath
    import cache_types_pkg::*;
    import bus_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  logic     way_sel,
    input  logic     data_source_sel,  // 0 selects the CPU, 1 selects memory
    input  logic     tag_bypass_sel,   // 0 sends the victim tag, 1 the request tag
    input  logic     load,
    input  logic     load_lru,

    input  wb_addr_t cpu_adr,
    input  wb_sel_t  cpu_sel,
    input  wb_data_t cpu_dat_w,
    input  wb_data_t mem_dat_r,

    output logic     hit_0,
    output logic     hit_1,
    output logic     dirty,
    output logic     lru,

    output wb_data_t cpu_dat_r,
    output wb_addr_t mem_adr,
    output wb_data_t mem_dat_w
);

    cache_line_t  data_in;
    wb_sel_t      byte_sel;
    cache_tag_t   tag_in;
    cache_index_t index;

    cache_line_t  data_0;
    cache_line_t  data_1;
    cache_line_t  data_out;
    cache_tag_t   tag_0;
    cache_tag_t   tag_1;
    cache_tag_t   tag_out;
    cache_tag_t   adr_tag;
    logic         dirty_0;
    logic         dirty_1;
    logic         load_0;
    logic         load_1;

    logic         lru_arr [`L1_SETS];

    // Input steering
    assign data_in  = data_source_sel ? mem_dat_r : cpu_dat_w;
    assign byte_sel = data_source_sel ? WB_SEL_ALL : cpu_sel;
    assign tag_in   = cpu_adr[`L1_ADDR_BITS-1:`L1_INDEX_BITS];
    assign index    = cpu_adr[`L1_INDEX_BITS-1:0];

    // Load goes only to the selected way
    assign load_0 = load & ~way_sel;
    assign load_1 = load & way_sel;

    cache_way u_way_0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load_0),
        .load_type (data_source_sel),
        .byte_sel  (byte_sel),
        .tag_in    (tag_in),
        .index     (index),
        .data_in   (data_in),
        .tag_out   (tag_0),
        .data_out  (data_0),
        .dirty     (dirty_0),
        .hit       (hit_0)
    );

    cache_way u_way_1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load_1),
        .load_type (data_source_sel),
        .byte_sel  (byte_sel),
        .tag_in    (tag_in),
        .index     (index),
        .data_in   (data_in),
        .tag_out   (tag_1),
        .data_out  (data_1),
        .dirty     (dirty_1),
        .hit       (hit_1)
    );

    // Output steering
    assign data_out  = way_sel ? data_1 : data_0;
    assign tag_out   = way_sel ? tag_1 : tag_0;
    assign adr_tag   = tag_bypass_sel ? tag_in : tag_out;
    assign cpu_dat_r = data_out;
    assign mem_dat_w = data_out;             // Victim line during write-back
    assign mem_adr   = {adr_tag, index};

    // Victim status for the controller
    assign lru   = lru_arr[index];
    assign dirty = lru ? dirty_1 : dirty_0;

    // LRU bit names the way to evict next
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `L1_SETS; i++) begin
                lru_arr[i] <= 1'b0;
            end
        end else if (load_lru) begin
            lru_arr[index] <= ~way_sel;
        end
    end

    // A line lives in at most one way, which relies on fills happening only after a miss
    a_single_hit : assert property (
        @(posedge clk) disable iff (!rst_n)
        !(hit_0 && hit_1)
    );

endmodule : cache_l1_datapath

// File: design/cache_l1_control.sv
`timescale 1ns/10ps
`include "l1_cache_defines.svh"

module cache_l1_control
    import cache_types_pkg::*;
(
    input  logic clk,
    input  logic rst_n,

    input  logic cpu_stb,
    input  logic cpu_cyc,
    input  logic cpu_we,

    input  logic hit_0,
    input  logic hit_1,
    input  logic dirty,
    input  logic lru,
    input  logic mem_ack,

    output logic way_sel,
    output logic data_source_sel,
    output logic tag_bypass_sel,
    output logic load,
    output logic load_lru,
    output logic cpu_ack,
    output logic mem_cyc,
    output logic mem_stb,
    output logic mem_we
);

    cache_state_t state;
    cache_state_t state_next;
    logic         cpu_req;
    logic         hit;
    logic         mem_gap;   // One quiet bus cycle after each memory acknowledge
    logic         mem_req;
    logic         mem_done;

    assign cpu_req  = cpu_cyc && cpu_stb;
    assign hit      = hit_0 || hit_1;
    assign mem_req  = (state != IDLE) && !mem_gap;
    assign mem_done = mem_req && mem_ack;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            mem_gap <= 1'b0;
        end else begin
            state   <= state_next;
            mem_gap <= mem_done;  // Drops stb and cyc right after the acknowledge
        end
    end

    always_comb begin
        state_next      = state;
        way_sel         = lru;   // Victim way unless a hit says otherwise
        data_source_sel = 1'b0;
        tag_bypass_sel  = 1'b1;
        load            = 1'b0;
        load_lru        = 1'b0;
        cpu_ack         = 1'b0;
        mem_we          = 1'b0;

        case (state)
            IDLE: begin
                if (cpu_req) begin
                    if (hit) begin
                        way_sel  = hit_1;
                        cpu_ack  = 1'b1;
                        load_lru = 1'b1;
                        load     = cpu_we;  // Store merges its bytes on this edge
                    end else if (dirty) begin
                        state_next = WRITEBACK;
                    end else begin
                        state_next = FILL;
                    end
                end
            end

            WRITEBACK: begin
                tag_bypass_sel = 1'b0;  // Address of the line being evicted
                mem_we         = mem_req;
                if (mem_done) begin
                    state_next = FILL;
                end
            end

            FILL: begin
                data_source_sel = 1'b1;
                if (mem_done) begin
                    load       = 1'b1;
                    state_next = IDLE;  // Lookup repeats and now hits
                end
            end

            default: begin
                state_next = IDLE;
            end
        endcase
    end

    assign mem_cyc = mem_req;
    assign mem_stb = mem_req;

    // Memory request is held steady until it is acknowledged
    a_mem_hold : assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_stb && !mem_ack) |=> (mem_stb && mem_cyc && $stable(mem_we))
    );

    // The lookup repeated after a fill finds the new line and answers the CPU
    a_fill_then_ack : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == FILL && mem_done) |=> cpu_ack
    );

endmodule : cache_l1_control

// File: design/cache_l1.sv
`timescale 1ns/10ps
`include "l1_cache_defines.svh"

module cache_l1
    import bus_types_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    // CPU side, Wishbone slave
    input  logic     cpu_cyc,
    input  logic     cpu_stb,
    input  logic     cpu_we,
    input  wb_addr_t cpu_adr,
    input  wb_sel_t  cpu_sel,
    input  wb_data_t cpu_dat_w,
    output wb_data_t cpu_dat_r,
    output logic     cpu_ack,

    // Memory side, Wishbone master
    output logic     mem_cyc,
    output logic     mem_stb,
    output logic     mem_we,
    output wb_addr_t mem_adr,
    output wb_sel_t  mem_sel,
    output wb_data_t mem_dat_w,
    input  wb_data_t mem_dat_r,
    input  logic     mem_ack
);

    logic way_sel;
    logic data_source_sel;
    logic tag_bypass_sel;
    logic load;
    logic load_lru;
    logic hit_0;
    logic hit_1;
    logic dirty;
    logic lru;

    assign mem_sel = WB_SEL_ALL;  // Line transfers only

    cache_l1_control u_control (
        .clk             (clk),
        .rst_n           (rst_n),
        .cpu_stb         (cpu_stb),
        .cpu_cyc         (cpu_cyc),
        .cpu_we          (cpu_we),
        .hit_0           (hit_0),
        .hit_1           (hit_1),
        .dirty           (dirty),
        .lru             (lru),
        .mem_ack         (mem_ack),
        .way_sel         (way_sel),
        .data_source_sel (data_source_sel),
        .tag_bypass_sel  (tag_bypass_sel),
        .load            (load),
        .load_lru        (load_lru),
        .cpu_ack         (cpu_ack),
        .mem_cyc         (mem_cyc),
        .mem_stb         (mem_stb),
        .mem_we          (mem_we)
    );

    cache_l1_datapath u_datapath (
        .clk             (clk),
        .rst_n           (rst_n),
        .way_sel         (way_sel),
        .data_source_sel (data_source_sel),
        .tag_bypass_sel  (tag_bypass_sel),
        .load            (load),
        .load_lru        (load_lru),
        .cpu_adr         (cpu_adr),
        .cpu_sel         (cpu_sel),
        .cpu_dat_w       (cpu_dat_w),
        .mem_dat_r       (mem_dat_r),
        .hit_0           (hit_0),
        .hit_1           (hit_1),
        .dirty           (dirty),
        .lru             (lru),
        .cpu_dat_r       (cpu_dat_r),
        .mem_adr         (mem_adr),
        .mem_dat_w       (mem_dat_w)
    );

endmodule : cache_l1

// File: dv/wb_mem_model.sv
`timescale 1ns/10ps
`include "l1_cache_defines.svh"

module wb_mem_model
    import bus_types_pkg::*;
#(
    parameter int LOG_DEPTH = 1024
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cyc,
    input  logic       stb,
    input  logic       we,
    input  wb_addr_t   adr,
    input  wb_sel_t    sel,
    input  wb_data_t   dat_w,
    output wb_data_t   dat_r,
    output logic       ack,
    input  logic [2:0] ack_delay  // Extra wait cycles before each acknowledge
);

    wb_data_t mem [1 << `L1_ADDR_BITS];

    // Every acknowledged transaction in order, written lines and returned lines alike
    logic     log_we  [LOG_DEPTH];
    wb_addr_t log_adr [LOG_DEPTH];
    wb_data_t log_dat [LOG_DEPTH];
    int       log_count;
    int       wait_cnt;

    task automatic preload(input wb_addr_t a, input wb_data_t d);
        mem[a] = d;
    endtask

    function automatic wb_data_t apply_sel(input wb_data_t old_line, input wb_data_t new_line,
                                           input wb_sel_t mask);
        wb_data_t result;
        result = old_line;
        for (int i = 0; i < `L1_SEL_BITS; i++) begin
            if (mask[i]) begin
                result[8*i +: 8] = new_line[8*i +: 8];
            end
        end
        return result;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack       <= 1'b0;
            dat_r     <= '0;
            wait_cnt  <= 0;
            log_count <= 0;
        end else if (ack) begin
            ack      <= 1'b0;  // Acknowledge lasts one cycle
            wait_cnt <= 0;
        end else if (cyc && stb) begin
            if (wait_cnt >= ack_delay) begin
                ack                <= 1'b1;
                log_we[log_count]  <= we;
                log_adr[log_count] <= adr;
                if (we) begin
                    mem[adr]           <= apply_sel(mem[adr], dat_w, sel);
                    log_dat[log_count] <= dat_w;
                end else begin
                    dat_r              <= mem[adr];
                    log_dat[log_count] <= mem[adr];
                end
                log_count <= log_count + 1;
            end else begin
                wait_cnt <= wait_cnt + 1;  // Back-pressure toward the cache
            end
        end
    end

endmodule : wb_mem_model

// File: dv/cache_l1_tb.sv
`timescale 1ns/10ps
`include "l1_cache_defines.svh"

module cache_l1_tb
    import bus_types_pkg::*;
();

    localparam int          HALF_PERIOD  = 20;
    localparam int          RESET_CYCLES = 16;
    localparam int          RANDOM_OPS   = 200;
    localparam int          LINES        = 1 << `L1_ADDR_BITS;
    localparam int          WAYS         = 2;
    localparam logic [31:0] SEED         = 32'hae179f28;
    // About 220 requests of under 20 cycles each with write-back, fill and a 5 cycle
    // memory delay, plus reset, with a margin of four
    localparam int          TIMEOUT_CYCLES = 20000;

    logic       clk;
    logic       rst_n;
    logic       cpu_cyc;
    logic       cpu_stb;
    logic       cpu_we;
    wb_addr_t   cpu_adr;
    wb_sel_t    cpu_sel;
    wb_data_t   cpu_dat_w;
    wb_data_t   cpu_dat_r;
    logic       cpu_ack;
    logic       mem_cyc;
    logic       mem_stb;
    logic       mem_we;
    wb_addr_t   mem_adr;
    wb_sel_t    mem_sel;
    wb_data_t   mem_dat_w;
    wb_data_t   mem_dat_r;
    logic       mem_ack;
    logic [2:0] mem_delay;

    // What the CPU should read, and the expected tag, valid, dirty and LRU state
    wb_data_t                shadow_mem [LINES];
    logic [`L1_TAG_BITS-1:0] sh_tag     [WAYS*`L1_SETS];
    logic                    sh_valid   [WAYS*`L1_SETS];
    logic                    sh_dirty   [WAYS*`L1_SETS];
    logic                    sh_lru     [`L1_SETS];

    logic [31:0] rng;
    wb_data_t    rdata;      // Read data of the last request
    int          latency;    // Cycles from request to cpu_ack
    int          log_start;  // First memory log entry of the last request
    int          tests;
    int          checks;
    int          errors;
    int          cycle_count = 0;

    cache_l1 uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .cpu_cyc   (cpu_cyc),
        .cpu_stb   (cpu_stb),
        .cpu_we    (cpu_we),
        .cpu_adr   (cpu_adr),
        .cpu_sel   (cpu_sel),
        .cpu_dat_w (cpu_dat_w),
        .cpu_dat_r (cpu_dat_r),
        .cpu_ack   (cpu_ack),
        .mem_cyc   (mem_cyc),
        .mem_stb   (mem_stb),
        .mem_we    (mem_we),
        .mem_adr   (mem_adr),
        .mem_sel   (mem_sel),
        .mem_dat_w (mem_dat_w),
        .mem_dat_r (mem_dat_r),
        .mem_ack   (mem_ack)
    );

    wb_mem_model u_mem (
        .clk       (clk),
        .rst_n     (rst_n),
        .cyc       (mem_cyc),
        .stb       (mem_stb),
        .we        (mem_we),
        .adr       (mem_adr),
        .sel       (mem_sel),
        .dat_w     (mem_dat_w),
        .dat_r     (mem_dat_r),
        .ack       (mem_ack),
        .ack_delay (mem_delay)
    );

    always #(HALF_PERIOD) clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the cache never answered", cycle_count);
            $display("Something failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng = xorshift32(rng);
        return rng;
    endfunction

    function automatic wb_data_t random_line();
        wb_data_t d;
        for (int k = 0; k < 4; k++) begin
            d[32*k +: 32] = next_random();
        end
        return d;
    endfunction

    // Memory content at reset, a distinct pattern for every line address
    function automatic wb_data_t initial_line(input wb_addr_t a);
        logic [31:0] s;
        wb_data_t    pattern;
        s = SEED ^ ({20'd0, a} * 32'h9e3779b1);
        for (int k = 0; k < 4; k++) begin
            s = xorshift32(s);
            pattern[32*k +: 32] = s;
        end
        return pattern;
    endfunction

    function automatic wb_data_t merge_bytes(input wb_data_t old_line, input wb_data_t new_line,
                                             input wb_sel_t sel);
        wb_data_t result;
        result = old_line;
        for (int i = 0; i < `L1_SEL_BITS; i++) begin
            if (sel[i]) begin
                result[8*i +: 8] = new_line[8*i +: 8];
            end
        end
        return result;
    endfunction

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %0h got %0h at %0t", name, expected, actual, $time);
        end
    endtask

    // One CPU request, with the memory traffic predicted from the shadow state
    task automatic cpu_request(input logic we, input wb_addr_t adr, input wb_sel_t sel,
                               input wb_data_t dat);
        int       idx;
        int       way;
        int       exp_n;
        logic     hit_expected;
        logic     exp_we  [2];
        wb_addr_t exp_adr [2];
        wb_data_t exp_dat [2];
        wb_addr_t victim_adr;
        idx   = adr[`L1_INDEX_BITS-1:0];
        way   = -1;
        exp_n = 0;
        for (int w = 0; w < WAYS; w++) begin
            if (sh_valid[WAYS*idx+w] && sh_tag[WAYS*idx+w] == adr[`L1_ADDR_BITS-1:`L1_INDEX_BITS])
                way = w;
        end
        hit_expected = (way >= 0);
        if (!hit_expected) begin
            way        = sh_lru[idx];
            victim_adr = {sh_tag[WAYS*idx+way], adr[`L1_INDEX_BITS-1:0]};
            if (sh_valid[WAYS*idx+way] && sh_dirty[WAYS*idx+way]) begin
                exp_we[0]  = 1'b1;  // Dirty victim goes out before the fill
                exp_adr[0] = victim_adr;
                exp_dat[0] = shadow_mem[victim_adr];
                exp_n      = 1;
            end
            exp_we[exp_n]  = 1'b0;
            exp_adr[exp_n] = adr;
            exp_dat[exp_n] = shadow_mem[adr];
            exp_n++;
            sh_tag[WAYS*idx+way]   = adr[`L1_ADDR_BITS-1:`L1_INDEX_BITS];
            sh_valid[WAYS*idx+way] = 1'b1;
            sh_dirty[WAYS*idx+way] = 1'b0;
        end
        sh_lru[idx] = (way == 0);  // Points at the way not just used
        if (we) begin
            sh_dirty[WAYS*idx+way] = 1'b1;
            shadow_mem[adr]        = merge_bytes(shadow_mem[adr], dat, sel);
        end

        log_start = u_mem.log_count;
        @(negedge clk);
        cpu_cyc   = 1'b1;
        cpu_stb   = 1'b1;
        cpu_we    = we;
        cpu_adr   = adr;
        cpu_sel   = sel;
        cpu_dat_w = dat;
        latency   = 0;
        #(HALF_PERIOD / 2);
        while (cpu_ack !== 1'b1) begin
            @(negedge clk);
            #(HALF_PERIOD / 2);
            latency++;
        end
        rdata = cpu_dat_r;
        @(negedge clk);
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_we  = 1'b0;

        check("mem_ack count", exp_n, u_mem.log_count - log_start);
        for (int i = 0; i < exp_n; i++) begin
            check("mem_we", exp_we[i], u_mem.log_we[log_start+i]);
            check("mem_adr", exp_adr[i], u_mem.log_adr[log_start+i]);
            check(exp_we[i] ? "mem_dat_w" : "mem_dat_r", exp_dat[i], u_mem.log_dat[log_start+i]);
        end
        if (!we) begin
            check("cpu_dat_r", shadow_mem[adr], rdata);
        end
        if (hit_expected) begin
            check("cpu_ack delay", 0, latency);
        end
    endtask

    task automatic end_test(input string name, input int err_start);
        tests++;
        $display("Test %0d %s: %0d errors", tests, name, errors - err_start);
    endtask

    task automatic test_cold_read_miss();
        int err_start;
        err_start = errors;
        check("cpu_ack", 1'b0, cpu_ack);  // Both ports come out of reset idle
        check("mem_cyc", 1'b0, mem_cyc);
        check("mem_stb", 1'b0, mem_stb);
        check("mem_we", 1'b0, mem_we);
        check("mem_sel", 16'hffff, mem_sel);
        cpu_request(1'b0, 12'h123, '0, '0);
        check("cpu_dat_r", initial_line(12'h123), rdata);
        check("mem_we", 1'b0, u_mem.log_we[log_start]);
        end_test("cold read miss", err_start);
    endtask

    task automatic test_read_hit();
        int err_start;
        err_start = errors;
        cpu_request(1'b0, 12'h123, '0, '0);
        check("cpu_dat_r", initial_line(12'h123), rdata);
        check("cpu_ack delay", 0, latency);
        end_test("read hit", err_start);
    endtask

    task automatic test_write_hit();
        int       err_start;
        wb_data_t wdata;
        wb_data_t mask;
        wb_data_t expected;
        err_start = errors;
        wdata     = random_line();
        mask      = 128'h0000_0000_ffff_ffff_ffff_ffff_0000_0000;  // Bytes 4 to 11
        expected  = (initial_line(12'h123) & ~mask) | (wdata & mask);
        cpu_request(1'b1, 12'h123, 16'h0ff0, wdata);
        cpu_request(1'b0, 12'h123, '0, '0);
        check("cpu_dat_r", expected, rdata);
        end_test("byte-masked write hit", err_start);
    endtask

    task automatic test_lru_eviction();
        int       err_start;
        wb_data_t wdata;
        wb_data_t line_a;
        wb_data_t expected_a;
        err_start  = errors;
        wdata      = random_line();
        line_a     = initial_line(12'h015);
        expected_a = {line_a[127:32], wdata[31:0]};
        cpu_request(1'b0, 12'h015, '0, '0);  // A, B and C all map to set 5
        cpu_request(1'b0, 12'h025, '0, '0);
        cpu_request(1'b1, 12'h015, 16'h000f, wdata);
        cpu_request(1'b0, 12'h035, '0, '0);  // Clean B is the victim
        check("mem_ack count", 1, u_mem.log_count - log_start);
        check("mem_adr", 12'h035, u_mem.log_adr[log_start]);
        cpu_request(1'b0, 12'h015, '0, '0);
        check("cpu_ack delay", 0, latency);
        check("cpu_dat_r", expected_a, rdata);
        cpu_request(1'b0, 12'h035, '0, '0);  // Leaves A least recently used
        cpu_request(1'b0, 12'h025, '0, '0);
        check("mem_we", 1'b1, u_mem.log_we[log_start]);
        check("mem_adr", 12'h015, u_mem.log_adr[log_start]);
        check("mem_dat_w", expected_a, u_mem.log_dat[log_start]);
        check("mem_we", 1'b0, u_mem.log_we[log_start+1]);
        end_test("LRU eviction with write-back", err_start);
    endtask

    task automatic test_write_miss();
        int       err_start;
        wb_data_t wdata;
        wb_data_t line_d;
        wb_data_t expected_d;
        err_start  = errors;
        wdata      = random_line();
        line_d     = initial_line(12'h046);
        expected_d = {wdata[127:64], line_d[63:0]};
        cpu_request(1'b1, 12'h046, 16'hff00, wdata);
        check("mem_we", 1'b0, u_mem.log_we[log_start]);
        cpu_request(1'b0, 12'h056, '0, '0);
        cpu_request(1'b0, 12'h066, '0, '0);  // Evicts the written line
        check("mem_adr", 12'h046, u_mem.log_adr[log_start]);
        check("mem_dat_w", expected_d, u_mem.log_dat[log_start]);
        end_test("write miss allocation", err_start);
    endtask

    task automatic test_random_slow_memory();
        int          err_start;
        int          k;
        logic [31:0] r;
        err_start = errors;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            r         = next_random();
            k         = r % 24;  // Six tags over sets 0 to 3
            mem_delay = 3'(r[15:8] % 6);
            cpu_request(r[16], wb_addr_t'((k / 4) * 8 + k % 4), wb_sel_t'(next_random()),
                        random_line());
        end
        end_test("random sequence with slow memory", err_start);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        cpu_cyc   = 1'b0;
        cpu_stb   = 1'b0;
        cpu_we    = 1'b0;
        cpu_adr   = '0;
        cpu_sel   = '0;
        cpu_dat_w = '0;
        mem_delay = 3'd2;
        rng       = SEED;
        tests     = 0;
        checks    = 0;
        errors    = 0;
        for (int a = 0; a < LINES; a++) begin
            shadow_mem[a] = initial_line(a);
            u_mem.preload(a, shadow_mem[a]);
        end
        for (int i = 0; i < WAYS * `L1_SETS; i++) begin
            sh_tag[i]   = '0;
            sh_valid[i] = 1'b0;
            sh_dirty[i] = 1'b0;
        end
        for (int i = 0; i < `L1_SETS; i++) begin
            sh_lru[i] = 1'b0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        test_cold_read_miss();
        test_read_hit();
        test_write_hit();
        test_lru_eviction();
        test_write_miss();
        test_random_slow_memory();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule : cache_l1_tb

// File: cache_l1.f
+incdir+design
design/cache_types_pkg.sv
design/bus_types_pkg.sv
design/cache_way.sv
design/cache_l1_datapath.sv
design/cache_l1_control.sv
design/cache_l1.sv
dv/wb_mem_model.sv
dv/cache_l1_tb.sv

// File: Bender.yml
package:
  name: cache_l1

sources:
  - include_dirs:
      - design
    files:
      - design/cache_types_pkg.sv
      - design/bus_types_pkg.sv
      - design/cache_way.sv
      - design/cache_l1_datapath.sv
      - design/cache_l1_control.sv
      - design/cache_l1.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/wb_mem_model.sv
      - dv/cache_l1_tb.sv
